// ==== source/lsu_pkg.sv ====
// Load/store unit package
// Transfer request and response types plus memory sizing and latency constants

package lsu_pkg;

  //////////////////////////////
  // Sizing and timing
  //////////////////////////////

  // Word address and data widths
  localparam int unsigned ADDR_W = 4;
  localparam int unsigned DATA_W = 32;

  // Number of data memory words
  localparam int unsigned MEM_WORDS = 16;

  // Cycles from acceptance at the protection check or memory to the response
  localparam int unsigned MEM_LATENCY = 2;

  // Writes at or above this word address are refused
  localparam logic [ADDR_W-1:0] PROT_BASE = 4'd12;

  // Highest number of transfers in flight that the counter may hold
  localparam int unsigned MAX_OUTSTANDING = 3;

  //////////////////////////////
  // Transfer types
  //////////////////////////////

  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_WR_FAULT = 2'b01
  } mpu_status_e;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    mpu_status_e       mpu_status;
    logic              wpt_match;
  } lsu_resp_t;

endpackage

// ==== source/dbg_pkg.sv ====
// Debug package
// Watchpoint trigger configuration and gate state encoding

package dbg_pkg;

  import lsu_pkg::*;

  // Number of load/store address triggers
  localparam int unsigned NUM_TRIGGERS = 2;

  // One address-match trigger, with separate load and store enables
  typedef struct packed {
    logic              en;
    logic              on_load;
    logic              on_store;
    logic [ADDR_W-1:0] addr;
  } trig_cfg_t;

  // Watchpoint gate states
  typedef enum logic [1:0] {
    WPT_IDLE       = 2'b00,
    WPT_MATCH_WAIT = 2'b01,
    WPT_MATCH_RESP = 2'b10
  } wpt_state_e;

endpackage

// ==== source/wpt_trigger_match.sv ====
// Watchpoint trigger matcher
// Holds the trigger settings and flags requests whose address and kind hit a trigger

module wpt_trigger_match
  import lsu_pkg::*;
  import dbg_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      trig_wr_i,
  input  logic      trig_idx_i,
  input  trig_cfg_t trig_cfg_i,
  input  logic      req_valid_i,
  input  lsu_req_t  req_i,
  output logic      trigger_match_o
);

  trig_cfg_t                   cfg_q [NUM_TRIGGERS];
  logic [NUM_TRIGGERS-1:0]     hit;

  // Configuration write port, one trigger per pulse
  // All triggers come out of reset disabled
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_TRIGGERS; i++) begin
        cfg_q[i] <= '0;
      end
    end else if (trig_wr_i) begin
      cfg_q[trig_idx_i] <= trig_cfg_i;
    end
  end

  // A trigger hits when it is enabled, the word address is equal and the
  // access kind is one the trigger watches
  always_comb begin
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      hit[i] = cfg_q[i].en && (cfg_q[i].addr == req_i.addr) &&
               (req_i.we ? cfg_q[i].on_store : cfg_q[i].on_load);
    end
  end

  // Only a request actually offered by the core can match
  assign trigger_match_o = req_valid_i && (|hit);

endmodule

// ==== source/lsu_outstanding.sv ====
// Outstanding transfer counter
// Tracks accepted transfers still waiting for a response and flags a next count of one

module lsu_outstanding
  import lsu_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic accept_i,
  input  logic resp_i,
  output logic one_txn_pend_n_o
);

  logic [$clog2(MAX_OUTSTANDING+1)-1:0] cnt_q;
  logic [$clog2(MAX_OUTSTANDING+1)-1:0] cnt_n;

  // Next count from this cycle's accept and response events
  // Both in the same cycle cancel out
  always_comb begin
    cnt_n = cnt_q;
    if (accept_i && !resp_i) begin
      cnt_n = cnt_q + 1'b1;
    end else if (resp_i && !accept_i) begin
      cnt_n = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_n;
    end
  end

  // Exactly one transfer will be in flight next cycle
  assign one_txn_pend_n_o = (cnt_n == 1);

  // A response must always belong to an earlier accepted transfer
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    resp_i |-> (cnt_q != '0))
    else $error("response seen with no transfer outstanding");

  // The pipelines never hold more transfers than the limit
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (accept_i && !resp_i) |-> (cnt_q < MAX_OUTSTANDING))
    else $error("outstanding count above %0d", MAX_OUTSTANDING);

endmodule

// ==== source/wpt_gate.sv ====
// Watchpoint gate
// Keeps triggered transfers off the bus and answers them once earlier transfers drain

module wpt_gate
  import lsu_pkg::*;
  import dbg_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // From the trigger matcher
  input  logic      trigger_match_i,

  // Core request and response
  input  logic      core_trans_valid_i,
  output logic      core_trans_ready_o,
  input  lsu_req_t  core_trans_i,
  output logic      core_resp_valid_o,
  output lsu_resp_t core_resp_o,

  // Exactly one transfer in flight next cycle
  input  logic      core_one_txn_pend_n_i,

  // Report matches only after in-flight transfers complete
  input  logic      core_wpt_wait_i,

  // Early match report to the core
  output logic      core_wpt_match_o,

  // Towards the protection check
  output logic      mpu_trans_valid_o,
  input  logic      mpu_trans_ready_i,
  output lsu_req_t  mpu_trans_o,
  input  logic      mpu_resp_valid_i,
  input  lsu_resp_t mpu_resp_i
);

  wpt_state_e state_q;
  wpt_state_e state_n;
  logic       block_core;
  logic       block_bus;
  logic       wpt_ready;
  logic       wpt_resp_valid;

  //////////////////////////////
  // Gate FSM
  //////////////////////////////

  // A triggered transfer is taken from the core but never reaches the bus.
  // The gate then holds off new transfers until only the consumed transfer
  // is left, and answers it itself
  always_comb begin
    state_n        = state_q;
    block_core     = 1'b0;
    block_bus      = 1'b0;
    wpt_ready      = 1'b0;
    wpt_resp_valid = 1'b0;

    case (state_q)
      WPT_IDLE: begin
        if (trigger_match_i && core_trans_valid_i) begin
          // Acknowledge at once, even while the bus is stalled
          block_bus = 1'b1;
          wpt_ready = 1'b1;
          if (core_wpt_wait_i) begin
            // With nothing else in flight the answer goes out next cycle
            state_n = core_one_txn_pend_n_i ? WPT_MATCH_RESP : WPT_MATCH_WAIT;
          end
        end
      end
      WPT_MATCH_WAIT: begin
        // Earlier transfers still draining, nothing new goes in
        block_bus  = 1'b1;
        block_core = 1'b1;
        if (core_one_txn_pend_n_i) begin
          state_n = WPT_MATCH_RESP;
        end
      end
      WPT_MATCH_RESP: begin
        block_bus      = 1'b1;
        block_core     = 1'b1;
        wpt_resp_valid = 1'b1;
        // The core always takes the response, so one cycle here is enough
        state_n        = WPT_IDLE;
      end
      default: begin
        state_n = WPT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= WPT_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  assign mpu_trans_valid_o = core_trans_valid_i && !block_bus;
  assign mpu_trans_o       = core_trans_i;

  // Ready is combinational through to the memory unless the gate blocks it
  assign core_trans_ready_o = (mpu_trans_ready_i && !block_core) || wpt_ready;

  // The gate's own answer carries the match flag and nothing else
  assign core_resp_valid_o      = mpu_resp_valid_i || wpt_resp_valid;
  assign core_resp_o.rdata      = wpt_resp_valid ? '0 : mpu_resp_i.rdata;
  assign core_resp_o.mpu_status = wpt_resp_valid ? MPU_OK : mpu_resp_i.mpu_status;
  assign core_resp_o.wpt_match  = wpt_resp_valid;

  assign core_wpt_match_o = trigger_match_i;

  // Draining must be complete before the gate answers, so a bus response
  // can never land on the same cycle
  a_no_resp_collision: assert property (@(posedge clk) disable iff (!rst_n)
    !(wpt_resp_valid && mpu_resp_valid_i))
    else $error("bus response collides with watchpoint response");

endmodule

// ==== source/mpu_check.sv ====
// Memory protection check
// Refuses writes to the protected region and answers them with a fault after the memory latency

module mpu_check
  import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  // From the watchpoint gate
  input  logic              trans_valid_i,
  output logic              trans_ready_o,
  input  lsu_req_t          trans_i,
  output logic              resp_valid_o,
  output lsu_resp_t         resp_o,

  // Towards the data memory
  output logic              mem_valid_o,
  input  logic              mem_ready_i,
  output lsu_req_t          mem_req_o,
  input  logic              mem_resp_valid_i,
  input  logic [DATA_W-1:0] mem_rdata_i
);

  logic                   prot_wr;
  logic                   accept;
  logic [MEM_LATENCY-1:0] fault_q;
  logic                   fault_valid;

  //////////////////////////////
  // Request side
  //////////////////////////////

  // Any write at or above the protected base is refused
  assign prot_wr = trans_i.we && (trans_i.addr >= PROT_BASE);

  // Ready follows the memory for every transfer, so back-pressure applies
  // equally to refused writes
  assign trans_ready_o = mem_ready_i;
  assign accept        = trans_valid_i && trans_ready_o;

  // Refused writes never reach memory
  assign mem_valid_o = trans_valid_i && !prot_wr;
  assign mem_req_o   = trans_i;

  //////////////////////////////
  // Fault pipeline
  //////////////////////////////

  // The fault marker travels as far as a memory response would, which keeps
  // responses in acceptance order
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      fault_q <= '0;
    end else begin
      fault_q <= {fault_q[MEM_LATENCY-2:0], accept && prot_wr};
    end
  end

  assign fault_valid = fault_q[MEM_LATENCY-1];

  // Merge both sources, a fault returns zero data
  assign resp_valid_o      = mem_resp_valid_i || fault_valid;
  assign resp_o.rdata      = fault_valid ? '0 : mem_rdata_i;
  assign resp_o.mpu_status = fault_valid ? MPU_WR_FAULT : MPU_OK;
  assign resp_o.wpt_match  = 1'b0;

  // Each accepted transfer goes down exactly one of the two equal-depth paths
  a_no_src_collision: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_resp_valid_i && fault_valid))
    else $error("memory response collides with protection fault");

endmodule

// ==== source/data_mem.sv ====
// Data memory
// Word memory with a fixed two-stage response pipeline and a stall input

module data_mem
  import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  lsu_req_t          req_i,
  input  logic              stall_i,
  output logic              resp_valid_o,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0]      mem_q [MEM_WORDS];
  logic [MEM_LATENCY-1:0] valid_q;
  logic [DATA_W-1:0]      data_q [MEM_LATENCY];
  logic                   accept;

  // Stall only holds off new requests, the pipeline keeps moving
  assign req_ready_o = !stall_i;
  assign accept      = req_valid_i && req_ready_o;

  // Storage starts out cleared, writes land at acceptance
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (accept && req_i.we) begin
      mem_q[req_i.addr] <= req_i.wdata;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[MEM_LATENCY-2:0], accept};
    end
  end

  // Read data is sampled at acceptance, a write echoes zero
  always_ff @(posedge clk) begin
    data_q[0] <= req_i.we ? '0 : mem_q[req_i.addr];
    for (int i = 1; i < MEM_LATENCY; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign resp_valid_o = valid_q[MEM_LATENCY-1];
  assign rdata_o      = data_q[MEM_LATENCY-1];

endmodule

// ==== source/lsu_wpt_top.sv ====
// Load/store data path top level
// Connects the trigger matcher, counter, watchpoint gate, protection check and memory

module lsu_wpt_top
  import lsu_pkg::*;
  import dbg_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      trig_wr_i,
  input  logic      trig_idx_i,
  input  trig_cfg_t trig_cfg_i,
  input  logic      core_trans_valid_i,
  output logic      core_trans_ready_o,
  input  lsu_req_t  core_trans_i,
  output logic      core_resp_valid_o,
  output lsu_resp_t core_resp_o,
  output logic      core_wpt_match_o,
  input  logic      bus_stall_i
);

  logic              trigger_match;
  logic              one_txn_pend_n;
  logic              mpu_trans_valid;
  logic              mpu_trans_ready;
  lsu_req_t          mpu_trans;
  logic              mpu_resp_valid;
  lsu_resp_t         mpu_resp;
  logic              mem_valid;
  logic              mem_ready;
  lsu_req_t          mem_req;
  logic              mem_resp_valid;
  logic [DATA_W-1:0] mem_rdata;

  wpt_trigger_match u_trig (
    .clk             (clk),
    .rst_n           (rst_n),
    .trig_wr_i       (trig_wr_i),
    .trig_idx_i      (trig_idx_i),
    .trig_cfg_i      (trig_cfg_i),
    .req_valid_i     (core_trans_valid_i),
    .req_i           (core_trans_i),
    .trigger_match_o (trigger_match)
  );

  // Events are taken at the core ports, the consumed transfer included
  lsu_outstanding u_outstanding (
    .clk              (clk),
    .rst_n            (rst_n),
    .accept_i         (core_trans_valid_i && core_trans_ready_o),
    .resp_i           (core_resp_valid_o),
    .one_txn_pend_n_o (one_txn_pend_n)
  );

  // No coprocessor requests here, so the gate always waits for draining
  wpt_gate u_gate (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .trigger_match_i       (trigger_match),
    .core_trans_valid_i    (core_trans_valid_i),
    .core_trans_ready_o    (core_trans_ready_o),
    .core_trans_i          (core_trans_i),
    .core_resp_valid_o     (core_resp_valid_o),
    .core_resp_o           (core_resp_o),
    .core_one_txn_pend_n_i (one_txn_pend_n),
    .core_wpt_wait_i       (1'b1),
    .core_wpt_match_o      (core_wpt_match_o),
    .mpu_trans_valid_o     (mpu_trans_valid),
    .mpu_trans_ready_i     (mpu_trans_ready),
    .mpu_trans_o           (mpu_trans),
    .mpu_resp_valid_i      (mpu_resp_valid),
    .mpu_resp_i            (mpu_resp)
  );

  mpu_check u_mpu (
    .clk              (clk),
    .rst_n            (rst_n),
    .trans_valid_i    (mpu_trans_valid),
    .trans_ready_o    (mpu_trans_ready),
    .trans_i          (mpu_trans),
    .resp_valid_o     (mpu_resp_valid),
    .resp_o           (mpu_resp),
    .mem_valid_o      (mem_valid),
    .mem_ready_i      (mem_ready),
    .mem_req_o        (mem_req),
    .mem_resp_valid_i (mem_resp_valid),
    .mem_rdata_i      (mem_rdata)
  );

  data_mem u_mem (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (mem_valid),
    .req_ready_o  (mem_ready),
    .req_i        (mem_req),
    .stall_i      (bus_stall_i),
    .resp_valid_o (mem_resp_valid),
    .rdata_o      (mem_rdata)
  );

endmodule

// ==== tests/tb_lsu_wpt.sv ====
// Testbench for the load/store watchpoint data path
// Drives random traffic and trigger setups and checks responses against a reference model

module tb_lsu_wpt
  import lsu_pkg::*;
  import dbg_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////
  // Run length and timing
  //////////////////////////////

  localparam int unsigned CLK_PERIOD     = 8;
  localparam int unsigned SAMPLE_DELAY   = CLK_PERIOD / 2 - 1;
  localparam int unsigned RST_CYCLES     = 8;
  localparam int unsigned N_RW           = 300;
  localparam int unsigned N_PROT         = 200;
  localparam int unsigned N_TRIG         = 300;
  localparam int unsigned N_WPT_SEQ      = 150;
  localparam int unsigned N_STALL        = 300;
  localparam int unsigned TOTAL_TXNS     = N_RW + N_PROT + N_TRIG + N_WPT_SEQ + N_STALL;
  // Budget per transfer, large enough to cover stalls and draining
  localparam int unsigned CYCLES_PER_TXN = 20;

  // One expected response and the rising edge where it must be seen
  typedef struct packed {
    lsu_resp_t   resp;
    logic [31:0] due;
  } exp_resp_t;

  logic      clk;
  logic      rst_n;
  logic      trig_wr;
  logic      trig_idx;
  trig_cfg_t trig_cfg;
  logic      core_valid;
  logic      core_ready;
  lsu_req_t  core_req;
  logic      resp_valid;
  lsu_resp_t resp;
  logic      wpt_match;
  logic      bus_stall;

  // Reference model state
  logic [DATA_W-1:0] mem_model [MEM_WORDS];
  trig_cfg_t         trig_model [NUM_TRIGGERS];
  exp_resp_t         exp_q [$];
  logic              wpt_open;

  // Stimulus knobs, percentages and address window
  integer      seed = 72;
  logic        gen_on;
  int unsigned p_valid;
  int unsigned p_write;
  int unsigned p_stall;
  int unsigned addr_lo;
  int unsigned addr_span;
  logic        burst_mode;
  int unsigned burst_left;
  logic        req_hold;
  logic        cfg_pend;
  logic        cfg_pend_idx;
  trig_cfg_t   cfg_pend_val;

  int unsigned cyc;
  int unsigned accepted;
  int unsigned err_cnt;
  int unsigned chk_cnt;
  int unsigned test_cnt;
  int unsigned test_err_base;
  int unsigned test_txn_base;

  lsu_wpt_top uut (
    .clk                (clk),
    .rst_n              (rst_n),
    .trig_wr_i          (trig_wr),
    .trig_idx_i         (trig_idx),
    .trig_cfg_i         (trig_cfg),
    .core_trans_valid_i (core_valid),
    .core_trans_ready_o (core_ready),
    .core_trans_i       (core_req),
    .core_resp_valid_o  (resp_valid),
    .core_resp_o        (resp),
    .core_wpt_match_o   (wpt_match),
    .bus_stall_i        (bus_stall)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic int unsigned rand_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic chance(int unsigned pct);
    return rand_below(100) < pct;
  endfunction

  // A trigger fires on an equal word address when it watches that access kind
  function automatic logic model_match(lsu_req_t req);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      if (trig_model[i].en && trig_model[i].addr == req.addr) begin
        if (req.we && trig_model[i].on_store) hit = 1'b1;
        if (!req.we && trig_model[i].on_load) hit = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic lsu_req_t next_request();
    lsu_req_t req;
    req.we    = chance(p_write);
    req.addr  = ADDR_W'(addr_lo + rand_below(addr_span));
    req.wdata = $random(seed);
    if (burst_mode) begin
      if (burst_left == 0) begin
        // Hit trigger 0 right behind the transfers before it
        req.addr   = trig_model[0].addr;
        burst_left = 1 + rand_below(2);
      end else begin
        // Any other word stays clear of trigger 0
        req.addr   = trig_model[0].addr + ADDR_W'(1 + rand_below(MEM_WORDS - 1));
        burst_left = burst_left - 1;
      end
    end
    return req;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cyc);
    end
  endtask

  task automatic report_failure(input string what);
    err_cnt++;
    $display("Failure at cycle %0d: %s", cyc, what);
  endtask

  // Builds the expected response at acceptance and updates the memory copy
  task automatic record_accept();
    exp_resp_t e;
    int unsigned last;
    e.resp.rdata      = '0;
    e.resp.mpu_status = MPU_OK;
    e.resp.wpt_match  = 1'b0;
    e.due             = cyc + MEM_LATENCY;
    if (model_match(core_req)) begin
      // Answered one edge after the last earlier response, or after acceptance
      last = cyc;
      if (exp_q.size() != 0 && exp_q[$].due > last) last = exp_q[$].due;
      e.due            = last + 1;
      e.resp.wpt_match = 1'b1;
      wpt_open         = 1'b1;
    end else if (core_req.we) begin
      if (core_req.addr >= PROT_BASE) e.resp.mpu_status = MPU_WR_FAULT;
      else mem_model[core_req.addr] = core_req.wdata;
    end else begin
      e.resp.rdata = mem_model[core_req.addr];
    end
    exp_q.push_back(e);
  endtask

  //////////////////////////////
  // One clock cycle
  //////////////////////////////

  task automatic step();
    logic      accept;
    logic      gate_busy;
    exp_resp_t head;
    @(negedge clk);
    trig_wr   = cfg_pend;
    trig_idx  = cfg_pend_idx;
    trig_cfg  = cfg_pend_val;
    cfg_pend  = 1'b0;
    bus_stall = chance(p_stall);
    // A request not yet taken stays on the port unchanged
    if (!req_hold) begin
      core_valid = gen_on && chance(p_valid);
      if (core_valid) core_req = next_request();
    end

    // Sample just before the rising edge, where everything has settled
    #(SAMPLE_DELAY);
    accept    = core_valid && core_ready;
    gate_busy = wpt_open;
    check_value("core_wpt_match_o", wpt_match, core_valid && model_match(core_req));

    // Ready drops while a watchpoint is open, and on a stall unless the request is triggered
    if (core_valid) begin
      check_value("core_trans_ready_o", core_ready,
                  !gate_busy && (model_match(core_req) || !bus_stall));
    end

    if (resp_valid) begin
      if (exp_q.size() == 0) begin
        report_failure("response strobe with no transfer outstanding");
      end else begin
        head = exp_q.pop_front();
        check_value("core_resp_o.rdata", resp.rdata, head.resp.rdata);
        check_value("core_resp_o.mpu_status", resp.mpu_status, head.resp.mpu_status);
        check_value("core_resp_o.wpt_match", resp.wpt_match, head.resp.wpt_match);
        check_value("core_resp_valid_o cycle", cyc, head.due);
        if (head.resp.wpt_match) wpt_open = 1'b0;
      end
    end
    while (exp_q.size() != 0 && exp_q[0].due < cyc) begin
      report_failure("an expected response never arrived");
      head = exp_q.pop_front();
      if (head.resp.wpt_match) wpt_open = 1'b0;
    end

    if (accept) begin
      if (gate_busy) report_failure("transfer accepted while a watchpoint was pending");
      if (bus_stall && !model_match(core_req)) begin
        report_failure("transfer accepted during a bus stall");
      end
      record_accept();
      accepted++;
      req_hold = 1'b0;
    end else begin
      req_hold = core_valid;
    end

    if (trig_wr) trig_model[trig_idx] = trig_cfg;
    @(posedge clk);
    cyc++;
  endtask

  //////////////////////////////
  // Test sequencing
  //////////////////////////////

  task automatic set_traffic(input int unsigned valid_pct, input int unsigned write_pct,
                             input int unsigned stall_pct, input int unsigned lo,
                             input int unsigned span);
    p_valid   = valid_pct;
    p_write   = write_pct;
    p_stall   = stall_pct;
    addr_lo   = lo;
    addr_span = span;
  endtask

  // Lets the pending request go through and waits for every response
  task automatic drain();
    gen_on  = 1'b0;
    p_stall = 0;
    while (req_hold || exp_q.size() != 0) step();
  endtask

  task automatic run_traffic(input int unsigned n);
    int unsigned start;
    start  = accepted;
    gen_on = 1'b1;
    while (accepted - start < n) step();
    drain();
  endtask

  task automatic write_trigger(input int unsigned idx, input trig_cfg_t cfg);
    cfg_pend     = 1'b1;
    cfg_pend_idx = idx[0];
    cfg_pend_val = cfg;
    step();
  endtask

  task automatic random_triggers();
    trig_cfg_t cfg;
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      cfg.en       = chance(80);
      cfg.on_load  = chance(60);
      cfg.on_store = chance(60);
      cfg.addr     = ADDR_W'(rand_below(MEM_WORDS));
      write_trigger(i, cfg);
    end
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d transfers, %0d errors", test_cnt, name,
             accepted - test_txn_base, err_cnt - test_err_base);
    test_err_base = err_cnt;
    test_txn_base = accepted;
  endtask

  // Watchdog sized from the total transfer count
  initial begin
    repeat (RST_CYCLES + TOTAL_TXNS * CYCLES_PER_TXN) @(posedge clk);
    $display("Run timed out with %0d responses still expected", exp_q.size());
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    trig_cfg_t cfg;
    rst_n        = 1'b0;
    trig_wr      = 1'b0;
    trig_idx     = 1'b0;
    trig_cfg     = '0;
    core_valid   = 1'b0;
    core_req     = '0;
    bus_stall    = 1'b0;
    gen_on       = 1'b0;
    burst_mode   = 1'b0;
    burst_left   = 0;
    req_hold     = 1'b0;
    cfg_pend     = 1'b0;
    cfg_pend_idx = 1'b0;
    cfg_pend_val = '0;
    wpt_open     = 1'b0;
    cyc          = 0;
    accepted     = 0;
    err_cnt      = 0;
    chk_cnt      = 0;
    test_cnt     = 0;
    test_err_base = 0;
    test_txn_base = 0;
    for (int i = 0; i < MEM_WORDS; i++) mem_model[i] = '0;
    for (int i = 0; i < NUM_TRIGGERS; i++) trig_model[i] = '0;
    set_traffic(0, 0, 0, 0, MEM_WORDS);
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Triggers are still off after reset
    set_traffic(70, 50, 0, 0, MEM_WORDS);
    run_traffic(N_RW);
    finish_test("random reads and writes");

    // Upper half of memory, so protected writes and their reads mix
    set_traffic(70, 50, 0, MEM_WORDS / 2, MEM_WORDS / 2);
    run_traffic(N_PROT);
    finish_test("protected region writes");

    random_triggers();
    set_traffic(70, 50, 0, 0, MEM_WORDS);
    run_traffic(N_TRIG);
    finish_test("random watchpoint triggers");

    // Trigger 0 on every access kind, trigger 1 off
    cfg.en       = 1'b1;
    cfg.on_load  = 1'b1;
    cfg.on_store = 1'b1;
    cfg.addr     = ADDR_W'(rand_below(MEM_WORDS));
    write_trigger(0, cfg);
    write_trigger(1, '0);
    burst_mode = 1'b1;
    burst_left = 1;
    set_traffic(100, 50, 0, 0, MEM_WORDS);
    run_traffic(N_WPT_SEQ);
    burst_mode = 1'b0;
    finish_test("watchpoint behind outstanding transfers");

    random_triggers();
    set_traffic(80, 50, 40, 0, MEM_WORDS);
    run_traffic(N_STALL);
    finish_test("random bus stalls");

    $display("tests %0d, transfers %0d, checks %0d, errors %0d",
             test_cnt, accepted, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
source/lsu_pkg.sv
source/dbg_pkg.sv
source/wpt_trigger_match.sv
source/lsu_outstanding.sv
source/wpt_gate.sv
source/mpu_check.sv
source/data_mem.sv
source/lsu_wpt_top.sv
tests/tb_lsu_wpt.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the load/store watchpoint testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_lsu_wpt -f files.f -o sim_tb_lsu_wpt
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/sim_tb_lsu_wpt)"
sim_rc=$?
printf '%s\n' "$sim_out"
if [ $sim_rc -ne 0 ]; then
  echo "Simulation exited with status $sim_rc"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1
